// File: hdl/armPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the single-cycle ARM core
// Word, register address and NZCV flags
// Condition, ALU op and immediate encodings
// Instruction layouts and their union
// Decoder control bundle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package armPkg;

   parameter int dataWidth = 32;  // Data and address word
   parameter int regCount  = 16;  // Architectural registers incl. R15

   typedef logic [dataWidth-1:0] wordT;
   typedef logic [$clog2(regCount)-1:0] regAddrT;

   typedef struct packed {
      logic n;  // Negative
      logic z;  // Zero
      logic c;  // Carry / no borrow
      logic v;  // Signed overflow
   } flagsT;

   // Condition field, 4'hf is reserved
   typedef enum logic [3:0] {
      condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
      condHi, condLs, condGe, condLt, condGt, condLe, condAl
   } condT;

   typedef enum logic [2:0] {
      aluAdd, aluSub, aluAnd, aluOrr, aluEor, aluBic, aluMov
   } aluOpT;

   typedef enum logic [1:0] {
      immData8,     // Zero-extended 8 bits
      immMem12,     // Zero-extended 12 bits
      immBranch24   // Sign-extended, word offset
   } immSrcT;

   // Data processing, op 2'b00
   typedef struct packed {
      condT        cond;
      logic [1:0]  op;
      logic        imm;      // Operand2 is an immediate
      logic [3:0]  funct;    // ALU function
      logic        s;        // Update flags
      regAddrT     rn;
      regAddrT     rd;
      logic [11:0] operand;  // imm8 or rm in [3:0]
   } dpFieldsT;

   // Load/store, op 2'b01
   typedef struct packed {
      condT        cond;
      logic [1:0]  op;
      logic [4:0]  funct;    // I, P, U, B, W
      logic        load;     // LDR when set
      regAddrT     rn;
      regAddrT     rd;
      logic [11:0] offset;
   } memFieldsT;

   // Branch, op 2'b10
   typedef struct packed {
      condT        cond;
      logic [1:0]  op;
      logic        imm;      // Always 1 for branch
      logic        link;     // BL
      logic [23:0] offset;   // Word offset from PC+8
   } brFieldsT;

   // Same word, layout picked by op
   typedef union packed {
      dpFieldsT  dp;
      memFieldsT mem;
      brFieldsT  br;
   } instrT;

   typedef struct packed {
      logic [2:0] regSrc;     // [0] A=R15, [1] B=rd, [2] write R14 with PC+4
      immSrcT     immSrc;
      logic       aluSrc;     // B from immediate
      logic       memToReg;
      logic       regW;
      logic       memW;
      logic       pcS;        // PC takes the result
      logic [1:0] flagW;      // [1] NZ, [0] CV
      aluOpT      aluOp;
      logic       memStrobe;  // Load or store
   } controlT;

endpackage

`default_nettype wire

// File: hdl/regFile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file, R0 to R14
// Two read ports, one write port
// R15 reads as PC+8
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module regFile #(
   parameter int dataWidth = armPkg::dataWidth
) (
   input  logic            clk,
   input  logic            writeEnable,
   input  armPkg::regAddrT readAddrA,
   input  armPkg::regAddrT readAddrB,
   input  armPkg::regAddrT writeAddr,
   input  armPkg::wordT    writeData,
   input  armPkg::wordT    pcPlus8,
   output armPkg::wordT    readDataA,
   output armPkg::wordT    readDataB
);
   import armPkg::*;

   logic [dataWidth-1:0] regs [regCount-1];   // No storage for R15

   always_ff @(posedge clk)
   begin
      if (writeEnable)
         regs[writeAddr] <= writeData;
   end

   assign readDataA = (readAddrA == '1) ? pcPlus8 : regs[readAddrA];
   assign readDataB = (readAddrB == '1) ? pcPlus8 : regs[readAddrB];

   noR15Write: assert property (@(posedge clk) writeEnable |-> writeAddr != '1)
      else $error("regFile: write to R15 reached the register file");

endmodule

`default_nettype wire

// File: hdl/aluUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU
// Shared add/subtract, AND, ORR, EOR, BIC
// MOV pass-through and NZCV flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module aluUnit #(
   parameter int dataWidth = armPkg::dataWidth
) (
   input  armPkg::wordT  srcA,
   input  armPkg::wordT  srcB,
   input  armPkg::aluOpT aluOp,
   output armPkg::wordT  result,
   output armPkg::flagsT flags
);
   import armPkg::*;

   logic                 subtract;
   logic                 arith;
   logic [dataWidth-1:0] bInv;     // B as seen by the adder
   logic [dataWidth:0]   sum;      // Top bit is the carry out

   assign subtract = (aluOp == aluSub);
   assign arith    = (aluOp == aluAdd) || subtract;
   assign bInv     = subtract ? ~srcB : srcB;

   // A - B as A + ~B + 1
   assign sum = {1'b0, srcA} + {1'b0, bInv} + {{dataWidth{1'b0}}, subtract};

   always_comb
   begin
      case (aluOp)
         aluAdd,
         aluSub:  result = sum[dataWidth-1:0];
         aluAnd:  result = srcA & srcB;
         aluOrr:  result = srcA | srcB;
         aluEor:  result = srcA ^ srcB;
         aluBic:  result = srcA & ~srcB;
         aluMov:  result = srcB;
         default: result = '0;
      endcase
   end

   assign flags.n = result[dataWidth-1];
   assign flags.z = (result == '0);
   assign flags.c = arith & sum[dataWidth];   // For SUB, set means no borrow
   // Same-sign adder inputs but sign flipped in the sum
   assign flags.v = arith & ~(srcA[dataWidth-1] ^ bInv[dataWidth-1])
                          & (srcA[dataWidth-1] ^ sum[dataWidth-1]);

endmodule

`default_nettype wire

// File: hdl/datapath.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath of the single-cycle core
// PC register and next-PC select
// Register addressing, immediate extend
// Operand and result selection
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module datapath #(
   parameter int dataWidth = armPkg::dataWidth
) (
   input  logic            clk,
   input  logic            reset,
   input  armPkg::instrT   instr,
   input  armPkg::controlT ctrl,
   input  logic            regWrite,
   input  logic            pcSrc,
   input  logic            pcReady,
   input  armPkg::wordT    readData,
   output armPkg::wordT    pc,
   output armPkg::wordT    aluResult,
   output armPkg::wordT    writeData,
   output armPkg::flagsT   aluFlags
);
   import armPkg::*;

   wordT    pcNext, pcPlus4, pcPlus8;
   wordT    extImm, srcA, srcB, result;
   wordT    regWData;
   regAddrT readAddrA, readAddrB, writeAddr;
   logic    rfWrite;

   assign pcPlus4 = pc + dataWidth'(4);
   assign pcPlus8 = pcPlus4 + dataWidth'(4);   // R15 value
   assign pcNext  = pcSrc ? result : pcPlus4;

   // PC holds while stalled
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         pc <= '0;
      else if (pcReady)
         pc <= pcNext;
   end

   assign readAddrA = ctrl.regSrc[0] ? '1 : instr.dp.rn;                // Branch reads R15
   assign readAddrB = ctrl.regSrc[1] ? instr.dp.rd : instr.dp.operand[3:0];
   assign writeAddr = ctrl.regSrc[2] ? regAddrT'(14) : instr.dp.rd;     // BL links to R14
   assign regWData  = ctrl.regSrc[2] ? pcPlus4 : result;
   // R15 writes go to the PC instead
   assign rfWrite   = regWrite & (writeAddr != '1);

   regFile #(.dataWidth(dataWidth)) regFile_i (
      .clk         (clk),
      .writeEnable (rfWrite),
      .readAddrA   (readAddrA),
      .readAddrB   (readAddrB),
      .writeAddr   (writeAddr),
      .writeData   (regWData),
      .pcPlus8     (pcPlus8),
      .readDataA   (srcA),
      .readDataB   (writeData)
   );

   always_comb
   begin
      case (ctrl.immSrc)
         immData8:    extImm = {{(dataWidth-8){1'b0}}, instr.dp.operand[7:0]};
         immMem12:    extImm = {{(dataWidth-12){1'b0}}, instr.mem.offset};
         immBranch24: extImm = {{(dataWidth-26){instr.br.offset[23]}}, instr.br.offset, 2'b00};
         default:     extImm = '0;
      endcase
   end

   assign srcB = ctrl.aluSrc ? extImm : writeData;

   aluUnit #(.dataWidth(dataWidth)) aluUnit_i (
      .srcA   (srcA),
      .srcB   (srcB),
      .aluOp  (ctrl.aluOp),
      .result (aluResult),
      .flags  (aluFlags)
   );

   assign result = ctrl.memToReg ? readData : aluResult;  // LDR takes memory data

endmodule

`default_nettype wire

// File: hdl/condUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Condition unit
// NZ and CV flag registers
// Condition check and write gating
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module condUnit (
   input  logic            clk,
   input  logic            reset,
   input  armPkg::condT    cond,
   input  armPkg::controlT ctrl,
   input  armPkg::flagsT   aluFlags,
   input  logic            pcReady,
   output logic            regWrite,
   output logic            memWrite,
   output logic            memStrobe,
   output logic            pcSrc
);
   import armPkg::*;

   flagsT      flags;      // Stored NZCV
   logic       condEx;     // Condition passed
   logic       execute;    // Passed, not stalled, not in reset
   logic [1:0] flagWrite;
   logic       ge;

   assign ge = (flags.n == flags.v);

   always_comb
   begin
      case (cond)
         condEq:  condEx = flags.z;
         condNe:  condEx = ~flags.z;
         condCs:  condEx = flags.c;
         condCc:  condEx = ~flags.c;
         condMi:  condEx = flags.n;
         condPl:  condEx = ~flags.n;
         condVs:  condEx = flags.v;
         condVc:  condEx = ~flags.v;
         condHi:  condEx = flags.c & ~flags.z;
         condLs:  condEx = ~flags.c | flags.z;
         condGe:  condEx = ge;
         condLt:  condEx = ~ge;
         condGt:  condEx = ~flags.z & ge;
         condLe:  condEx = flags.z | ~ge;
         condAl:  condEx = 1'b1;
         default: condEx = 1'b0;   // Reserved
      endcase
   end

   assign execute   = condEx & pcReady & ~reset;
   assign flagWrite = ctrl.flagW & {2{execute}};
   assign regWrite  = ctrl.regW & execute;
   assign memWrite  = ctrl.memW & execute;       // No store while stalled
   assign memStrobe = ctrl.memStrobe & execute;
   assign pcSrc     = ctrl.pcS & execute;

   // NZ half
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         {flags.n, flags.z} <= 2'b00;
      else if (flagWrite[1])
         {flags.n, flags.z} <= {aluFlags.n, aluFlags.z};
   end

   // CV half, add/subtract types only
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         {flags.c, flags.v} <= 2'b00;
      else if (flagWrite[0])
         {flags.c, flags.v} <= {aluFlags.c, aluFlags.v};
   end

   condReserved: assert property (@(posedge clk) disable iff (reset) cond != 4'hf)
      else $error("condUnit: reserved condition code");

endmodule

`default_nettype wire

// File: hdl/instrDecoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction decoder
// Main decoder per op field
// ALU-op decoder for data processing
// Flag-write and PC-write control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module instrDecoder (
   input  armPkg::instrT   instr,
   output armPkg::controlT ctrl
);
   import armPkg::*;

   aluOpT dpOp;      // ALU op for data processing
   logic  compare;   // TST, TEQ, CMP, CMN
   logic  arith;     // Add/subtract types touch C and V
   logic  branch;

   // ALU-operation decoder
   always_comb
   begin
      case (instr.dp.funct)
         4'b0000, 4'b1000: dpOp = aluAnd;  // AND, TST
         4'b0001, 4'b1001: dpOp = aluEor;  // EOR, TEQ
         4'b0010, 4'b1010: dpOp = aluSub;  // SUB, CMP
         4'b0100, 4'b1011: dpOp = aluAdd;  // ADD, CMN
         4'b1100:          dpOp = aluOrr;
         4'b1101:          dpOp = aluMov;  // Immediate form only
         4'b1110:          dpOp = aluBic;
         default:          dpOp = aluAdd;  // Not supported
      endcase
   end

   assign compare = (instr.dp.funct[3:2] == 2'b10);
   assign arith   = (dpOp == aluAdd) || (dpOp == aluSub);

   // Main decoder
   always_comb
   begin
      ctrl   = '0;
      branch = 1'b0;
      case (instr.dp.op)
         2'b00:
         begin
            ctrl.immSrc = immData8;
            ctrl.aluSrc = instr.dp.imm;
            ctrl.regW   = ~compare;     // Compares only set flags
            ctrl.aluOp  = dpOp;
            ctrl.flagW  = {instr.dp.s, instr.dp.s & arith};
         end
         2'b01:
         begin
            ctrl.regSrc    = instr.mem.load ? 3'b000 : 3'b010;  // STR reads rd on B
            ctrl.immSrc    = immMem12;
            ctrl.aluSrc    = 1'b1;
            ctrl.memToReg  = instr.mem.load;
            ctrl.regW      = instr.mem.load;
            ctrl.memW      = ~instr.mem.load;
            ctrl.aluOp     = aluAdd;        // Base plus offset
            ctrl.memStrobe = 1'b1;
         end
         2'b10:
         begin
            ctrl.regSrc = instr.br.link ? 3'b101 : 3'b001;  // Read R15, BL writes R14
            ctrl.immSrc = immBranch24;
            ctrl.aluSrc = 1'b1;
            ctrl.regW   = instr.br.link;
            ctrl.aluOp  = aluAdd;           // PC+8 plus offset
            branch      = 1'b1;
         end
         default:
         begin
            branch = 1'b0;                  // Unused op, no effect
         end
      endcase
      // Writing R15 redirects the PC
      ctrl.pcS = branch | (ctrl.regW & (instr.dp.rd == '1));
   end

   // Op 2'b11 is never fetched by a valid program
   always_comb
   begin
      assert final (instr.dp.op != 2'b11)
         else $error("instrDecoder: unused op encoding in %h", instr);
   end

endmodule

`default_nettype wire

// File: hdl/armCore.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-cycle ARM subset core, top level
// Decoder, condition unit and datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module armCore #(
   parameter int dataWidth = armPkg::dataWidth
) (
   input  logic          clk,
   input  logic          reset,
   output armPkg::wordT  pc,
   input  armPkg::instrT instr,
   output logic          memWrite,
   output logic          memStrobe,
   output armPkg::wordT  aluResult,
   output armPkg::wordT  writeData,
   input  armPkg::wordT  readData,
   input  logic          pcReady     // Low stalls the core
);
   import armPkg::*;

   controlT ctrl;
   flagsT   aluFlags;   // Fresh flags from the ALU
   logic    regWrite;
   logic    pcSrc;

   instrDecoder instrDecoder_i (
      .instr (instr),
      .ctrl  (ctrl)
   );

   condUnit condUnit_i (
      .clk       (clk),
      .reset     (reset),
      .cond      (instr.dp.cond),  // Same position in all layouts
      .ctrl      (ctrl),
      .aluFlags  (aluFlags),
      .pcReady   (pcReady),
      .regWrite  (regWrite),
      .memWrite  (memWrite),
      .memStrobe (memStrobe),
      .pcSrc     (pcSrc)
   );

   datapath #(.dataWidth(dataWidth)) datapath_i (
      .clk       (clk),
      .reset     (reset),
      .instr     (instr),
      .ctrl      (ctrl),
      .regWrite  (regWrite),
      .pcSrc     (pcSrc),
      .pcReady   (pcReady),
      .readData  (readData),
      .pc        (pc),
      .aluResult (aluResult),
      .writeData (writeData),
      .aluFlags  (aluFlags)
   );

endmodule

`default_nettype wire

// File: verification/armCoreTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the ARM subset core
// Instruction and data memory models
// Test file loading and random stalls
// Store and final-PC compare tasks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module armCoreTb;
   import armPkg::*;

   localparam int recordWords  = 3;      // Kind, address, data
   localparam int maxRecords   = 160;
   localparam int storeTimeout = 1000;   // Cycles
   localparam int pcTimeout    = 200;

   logic   clk     = 1'b0;
   logic   reset   = 1'b1;
   logic   pcReady = 1'b0;
   wordT   pc;
   wordT   aluResult;
   wordT   writeData;
   wordT   readData;
   instrT  instr;
   logic   memWrite;
   logic   memStrobe;

   wordT   testData [recordWords*maxRecords];
   wordT   imem [256];
   wordT   dmem [256];
   wordT   expAddr [$];    // Expected stores, in order
   wordT   expData [$];
   wordT   finalPc;
   wordT   stallDraw;
   integer seed = 32'hdff3;
   int     storeCount = 0;
   int     passCount  = 0;
   int     failCount  = 0;
   int     cycles;

   // Combinational memory ports
   assign instr    = imem[pc[9:2]];
   assign readData = dmem[aluResult[9:2]];

   armCore armCore_i (
      .clk       (clk),
      .reset     (reset),
      .pc        (pc),
      .instr     (instr),
      .memWrite  (memWrite),
      .memStrobe (memStrobe),
      .aluResult (aluResult),
      .writeData (writeData),
      .readData  (readData),
      .pcReady   (pcReady)
   );

   always #10 clk = ~clk;   // 20 ns period

   // Unloaded data words carry their own address
   function automatic wordT fillWord(input wordT addr);
      return {addr[15:0], addr[31:16]} ^ ~addr;
   endfunction

   task automatic loadTests();
      int   rec;
      logic done;
      wordT kind;
      wordT addr;
      wordT value;
      rec  = 0;
      done = 1'b0;
      while (!done && rec < maxRecords)
      begin
         kind  = testData[rec*recordWords];
         addr  = testData[rec*recordWords+1];
         value = testData[rec*recordWords+2];
         case (kind)
            32'd1:   imem[addr[9:2]] = value;   // Program word
            32'd2:   dmem[addr[9:2]] = value;   // Data preload
            32'd3:
            begin
               expAddr.push_back(addr);
               expData.push_back(value);
            end
            32'd4:   finalPc = addr;            // Branch-to-self
            default: done = 1'b1;
         endcase
         rec++;
      end
   endtask

   task automatic checkStore(input int index, input wordT wantAddr, input wordT wantData,
                             input wordT gotAddr, input wordT gotData);
      if (gotAddr !== wantAddr || gotData !== wantData)
      begin
         if (gotAddr !== wantAddr)
            $display("error: store %0d aluResult expected %h got %h", index, wantAddr, gotAddr);
         if (gotData !== wantData)
            $display("error: store %0d writeData expected %h got %h", index, wantData, gotData);
         failCount++;
      end
      else
      begin
         $display("store %0d ok: %h at %h", index, gotData, gotAddr);
         passCount++;
      end
   endtask

   task automatic expectPc(input wordT wantPc, input wordT gotPc);
      if (gotPc !== wantPc)
      begin
         $display("error: pc expected %h got %h after the program", wantPc, gotPc);
         failCount++;
      end
      else
      begin
         $display("final pc ok: %h", gotPc);
         passCount++;
      end
   endtask

   // Roughly one stalled cycle in four
   always @(negedge clk)
   begin
      stallDraw = $random(seed);
      pcReady   = (stallDraw[1:0] != 2'b00);
   end

   // Store port, sampled before the core's own updates
   always @(posedge clk)
   begin
      // Only loads and stores strobe, never while stalled
      if (!reset && memStrobe && (!pcReady || instr.dp.op != 2'b01))
      begin
         $display("memStrobe was high at pc %h outside an executed load or store", pc);
         failCount++;
      end
      if (!reset && !memStrobe && pcReady && instr.dp.op == 2'b01 && instr.dp.cond == condAl)
      begin
         $display("unconditional load or store at pc %h came without memStrobe", pc);
         failCount++;
      end
      if (memWrite)
      begin
         if (!pcReady)
         begin
            $display("store to %h happened while pcReady was low", aluResult);
            failCount++;
         end
         if (!memStrobe)
         begin
            $display("store to %h came without memStrobe", aluResult);
            failCount++;
         end
         if (storeCount < expAddr.size())
            checkStore(storeCount, expAddr[storeCount], expData[storeCount],
                       aluResult, writeData);
         else
         begin
            $display("unexpected store of %h to %h after the last expected one",
                     writeData, aluResult);
            failCount++;
         end
         dmem[aluResult[9:2]] = writeData;
         storeCount++;
      end
   end

   initial
   begin
      for (int i = 0; i < 256; i++)
         dmem[i] = fillWord(wordT'(i) << 2);
      $readmemh("verification/armTests.txt", testData);
      loadTests();
      if (expAddr.size() == 0)
      begin
         $display("the test file held no expected stores");
         failCount++;
      end

      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      cycles = 0;
      while (storeCount < expAddr.size() && cycles < storeTimeout)
      begin
         @(negedge clk);
         cycles++;
      end
      if (storeCount < expAddr.size())
      begin
         $display("timeout: only %0d of %0d expected stores happened",
                  storeCount, expAddr.size());
         failCount++;
      end

      cycles = 0;
      while (pc !== finalPc && cycles < pcTimeout)
      begin
         @(negedge clk);
         cycles++;
      end
      if (pc !== finalPc)
      begin
         $display("timeout: pc never reached the final branch-to-self");
         failCount++;
      end
      else
      begin
         repeat (4) @(negedge clk);   // Has to stay put
         expectPc(finalPc, pc);
      end

      $display("checks passed %0d, failed %0d", passCount, failCount);
      if (failCount == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: verification/armTests.txt
// Columns: kind address data, all hex
// Kind 1 program word, 2 data preload, 3 expected store in order, 4 final pc, 0 end
1 00000000 E3A00000 // MOV r0, #0
1 00000004 E3A01005 // MOV r1, #5
1 00000008 E3A020C3 // MOV r2, #0xC3
1 0000000C E5801200 // STR r1, [r0, #0x200]
1 00000010 E2813007 // ADD r3, r1, #7
1 00000014 E5803204 // STR r3, [r0, #0x204]
1 00000018 E0823001 // ADD r3, r2, r1
1 0000001C E5803208 // STR r3, [r0, #0x208]
1 00000020 E2423003 // SUB r3, r2, #3
1 00000024 E580320C // STR r3, [r0, #0x20C]
1 00000028 E0413002 // SUB r3, r1, r2
1 0000002C E5803210 // STR r3, [r0, #0x210]
1 00000030 E202300F // AND r3, r2, #0x0F
1 00000034 E5803214 // STR r3, [r0, #0x214]
1 00000038 E0023001 // AND r3, r2, r1
1 0000003C E5803218 // STR r3, [r0, #0x218]
1 00000040 E3813030 // ORR r3, r1, #0x30
1 00000044 E580321C // STR r3, [r0, #0x21C]
1 00000048 E1823001 // ORR r3, r2, r1
1 0000004C E5803220 // STR r3, [r0, #0x220]
1 00000050 E22230FF // EOR r3, r2, #0xFF
1 00000054 E5803224 // STR r3, [r0, #0x224]
1 00000058 E0223001 // EOR r3, r2, r1
1 0000005C E5803228 // STR r3, [r0, #0x228]
1 00000060 E3C2300F // BIC r3, r2, #0x0F
1 00000064 E580322C // STR r3, [r0, #0x22C]
1 00000068 E1C23001 // BIC r3, r2, r1
1 0000006C E5803230 // STR r3, [r0, #0x230]
1 00000070 E5904300 // LDR r4, [r0, #0x300]
1 00000074 E5905304 // LDR r5, [r0, #0x304]
1 00000078 E0846005 // ADD r6, r4, r5
1 0000007C E5806234 // STR r6, [r0, #0x234]
1 00000080 E5957208 // LDR r7, [r5, #0x208]
1 00000084 E2477001 // SUB r7, r7, #1
1 00000088 E5857138 // STR r7, [r5, #0x138]
1 0000008C E3510005 // CMP r1, #5
1 00000090 0580123C // STREQ r1, [r0, #0x23C]
1 00000094 15802240 // STRNE r2, [r0, #0x240]
1 00000098 25802240 // STRCS r2, [r0, #0x240]
1 0000009C 85801244 // STRHI r1, [r0, #0x244]
1 000000A0 95802244 // STRLS r2, [r0, #0x244]
1 000000A4 E1510002 // CMP r1, r2
1 000000A8 B5801248 // STRLT r1, [r0, #0x248]
1 000000AC A5801248 // STRGE r1, [r0, #0x248]
1 000000B0 4580224C // STRMI r2, [r0, #0x24C]
1 000000B4 35801250 // STRCC r1, [r0, #0x250]
1 000000B8 C5802254 // STRGT r2, [r0, #0x254]
1 000000BC D5802254 // STRLE r2, [r0, #0x254]
1 000000C0 E590830C // LDR r8, [r0, #0x30C]
1 000000C4 E3780001 // CMN r8, #1
1 000000C8 65808258 // STRVS r8, [r0, #0x258]
1 000000CC 7580125C // STRVC r1, [r0, #0x25C]
1 000000D0 A580125C // STRGE r1, [r0, #0x25C]
1 000000D4 5580225C // STRPL r2, [r0, #0x25C]
1 000000D8 E312003C // TST r2, #0x3C
1 000000DC 05801260 // STREQ r1, [r0, #0x260]
1 000000E0 65802264 // STRVS r2, [r0, #0x264]
1 000000E4 E33200C2 // TEQ r2, #0xC2
1 000000E8 15801268 // STRNE r1, [r0, #0x268]
1 000000EC 05802268 // STREQ r2, [r0, #0x268]
1 000000F0 EA000000 // B 0xF8
1 000000F4 E580226C // STR r2, [r0, #0x26C], skipped
1 000000F8 EB000001 // BL 0x104
1 000000FC E580E274 // STR r14, [r0, #0x274]
1 00000100 EAFFFFFE // B 0x100
1 00000104 E28F9000 // ADD r9, r15, #0
1 00000108 E5809270 // STR r9, [r0, #0x270]
1 0000010C E28EF000 // ADD r15, r14, #0
2 00000300 12345678
2 00000304 00000100
2 00000308 0000ABCD
2 0000030C 7FFFFFFF
3 00000200 00000005
3 00000204 0000000C
3 00000208 000000C8
3 0000020C 000000C0
3 00000210 FFFFFF42
3 00000214 00000003
3 00000218 00000001
3 0000021C 00000035
3 00000220 000000C7
3 00000224 0000003C
3 00000228 000000C6
3 0000022C 000000C0
3 00000230 000000C2
3 00000234 12345778
3 00000238 0000ABCC
3 0000023C 00000005
3 00000240 000000C3
3 00000244 000000C3
3 00000248 00000005
3 0000024C 000000C3
3 00000250 00000005
3 00000254 000000C3
3 00000258 7FFFFFFF
3 0000025C 00000005
3 00000260 00000005
3 00000264 000000C3
3 00000268 00000005
3 00000270 0000010C
3 00000274 000000FC
4 00000100 00000000
0 00000000 00000000

// File: project.f
hdl/armPkg.sv
hdl/regFile.sv
hdl/aluUnit.sv
hdl/datapath.sv
hdl/condUnit.sv
hdl/instrDecoder.sv
hdl/armCore.sv
verification/armCoreTb.sv

// File: Makefile
SIM = obj_dir/VarmCoreTb

.PHONY: all run clean

all: run

$(SIM): project.f hdl/*.sv verification/armCoreTb.sv
	verilator --binary --timing --assert -j 0 --top-module armCoreTb -Mdir obj_dir -f project.f

run: $(SIM) verification/armTests.txt
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
